/* hdl/pm_defs.svh */
/*
    Widths, address map, register indexes and constants shared by the peripherals.
    Include it in any file that needs one of these values.
*/
`ifndef PM_DEFS_SVH
`define PM_DEFS_SVH

`define PM_ADR_W            16      // Host byte address
`define PM_DAT_W            32
`define PM_PIO_W            8       // External PIO pins
`define PM_IRQ_NUM          4
`define PM_DEV_LSB          8       // Device index starts here
`define PM_DEV_W            4
`define PM_REG_W            3       // Register index starts at bit 2

`define PM_DEV_PIO          4'd1
`define PM_DEV_TMR          4'd2
`define PM_DEV_IRQ          4'd3
`define PM_PERIPH_SPACE     2'b11   // Address bits 15:14

`define PM_BEAT             125     // Clocks per timer beat
`define PM_HW_VER_MAJOR     8'd1
`define PM_HW_VER_MINOR     8'd0

// PIO registers
`define PM_PIO_VER          3'd0
`define PM_PIO_DIN          3'd1
`define PM_PIO_DOUT         3'd2
`define PM_PIO_SET          3'd3
`define PM_PIO_CLR          3'd4
`define PM_PIO_MASK         3'd5

// Timer registers
`define PM_TMR_CNT          3'd0
`define PM_TMR_ALARM        3'd1
`define PM_TMR_CTL          3'd2

// Interrupt controller registers
`define PM_IRQ_PEND         3'd0
`define PM_IRQ_MASK         3'd1

`endif

/* hdl/pm_pkg.sv */
/*
    Bus and interrupt types for the policy maker peripherals.
    Refer to them as pm_pkg::name.
*/
`include "pm_defs.svh"

package pm_pkg;

    // Register index on the local bus
    typedef logic [`PM_REG_W-1:0]   lb_adr_t;

    // Bus data word
    typedef logic [`PM_DAT_W-1:0]   lb_dat_t;

    // Host byte address
    typedef logic [`PM_ADR_W-1:0]   host_adr_t;

    // Interrupt requests
    // Bit 0 PIO, bit 1 timer, bits 3:2 external
    typedef logic [`PM_IRQ_NUM-1:0] irq_vec_t;

endpackage

/* hdl/pm_lb_if.sv */
/*
    Local bus between the address decoder and one peripheral.
    Write is a single wr strobe, read returns dout with vld one cycle after rd.
*/
`timescale 1ns/100ps

interface pm_lb_if;

    pm_pkg::lb_adr_t    adr;    // Register index
    pm_pkg::lb_dat_t    din;    // Write data
    logic               wr;
    logic               rd;
    pm_pkg::lb_dat_t    dout;   // Read data
    logic               vld;    // Read data valid

    // Decoder side
    modport ctl
    (
        output adr, din, wr, rd,
        input  dout, vld
    );

    // Peripheral side
    modport dev
    (
        input  adr, din, wr, rd,
        output dout, vld
    );

endinterface

/* hdl/pm_lb_decoder.sv */
/*
    Splits host accesses over the peripheral local buses and merges the read data.
    Reads outside the map still complete, returning zero one cycle later.
*/
`timescale 1ns/100ps
`include "pm_defs.svh"

module pm_lb_decoder
(
    input  logic                clk,
    input  logic                rst,

    // Host
    input  pm_pkg::host_adr_t   adr,
    input  logic                wr,
    input  logic                rd,
    input  pm_pkg::lb_dat_t     wr_dat,
    output pm_pkg::lb_dat_t     rd_dat,
    output logic                rd_vld,

    // Peripherals
    pm_lb_if.ctl                pio_lb,
    pm_lb_if.ctl                tmr_lb,
    pm_lb_if.ctl                irq_lb
);

    logic                   in_space;
    logic [`PM_DEV_W-1:0]   dev;
    logic                   sel_pio;
    logic                   sel_tmr;
    logic                   sel_irq;
    logic                   hit;
    pm_pkg::lb_adr_t        reg_idx;
    logic                   miss_vld;   // Valid for unmapped reads

    // Address fields
    assign in_space = (adr[`PM_ADR_W-1 -: 2] == `PM_PERIPH_SPACE);
    assign dev      = adr[`PM_DEV_LSB +: `PM_DEV_W];
    assign reg_idx  = adr[2 +: `PM_REG_W];  // Word aligned

    assign sel_pio  = in_space && (dev == `PM_DEV_PIO);
    assign sel_tmr  = in_space && (dev == `PM_DEV_TMR);
    assign sel_irq  = in_space && (dev == `PM_DEV_IRQ);
    assign hit      = sel_pio || sel_tmr || sel_irq;

    // PIO
    assign pio_lb.adr = reg_idx;
    assign pio_lb.din = wr_dat;
    assign pio_lb.wr  = wr && sel_pio;
    assign pio_lb.rd  = rd && sel_pio;

    // Timer
    assign tmr_lb.adr = reg_idx;
    assign tmr_lb.din = wr_dat;
    assign tmr_lb.wr  = wr && sel_tmr;
    assign tmr_lb.rd  = rd && sel_tmr;

    // Interrupt controller
    assign irq_lb.adr = reg_idx;
    assign irq_lb.din = wr_dat;
    assign irq_lb.wr  = wr && sel_irq;
    assign irq_lb.rd  = rd && sel_irq;

    // Unmapped read completes like a peripheral read
    always_ff @(posedge clk)
    begin
        if (rst)
            miss_vld <= 1'b0;
        else
            miss_vld <= rd && !hit;
    end

    // Read data mux
    always_comb
    begin
        if (pio_lb.vld)
            rd_dat = pio_lb.dout;
        else if (tmr_lb.vld)
            rd_dat = tmr_lb.dout;
        else if (irq_lb.vld)
            rd_dat = irq_lb.dout;
        else
            rd_dat = '0;    // Unmapped or idle
    end

    assign rd_vld = pio_lb.vld || tmr_lb.vld || irq_lb.vld || miss_vld;

endmodule

/* hdl/pm_pio.sv */
/*
    Parallel I/O registers for version, sampled inputs and an output with set and clear.
    Pulses irq when a masked input bit changes.
*/
`timescale 1ns/100ps
`include "pm_defs.svh"

module pm_pio
(
    input  logic                    clk,
    input  logic                    rst,
    pm_lb_if.dev                    lb,
    input  logic [`PM_PIO_W-1:0]    pio_in,
    output logic [`PM_PIO_W-1:0]    pio_out,
    output logic                    irq
);

    logic [`PM_PIO_W-1:0]   din_q;      // Input register
    logic [`PM_PIO_W-1:0]   din_prev;   // Compare register
    logic [`PM_PIO_W-1:0]   dout_q;
    logic [`PM_PIO_W-1:0]   mask_q;
    logic [`PM_PIO_W-1:0]   wdat;
    pm_pkg::lb_dat_t        rd_mux;

    assign wdat = lb.din[`PM_PIO_W-1:0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            din_q    <= '0;
            din_prev <= '0;
            dout_q   <= '0;
            mask_q   <= '0;
            irq      <= 1'b0;
        end
        else
        begin
            din_q    <= pio_in;
            din_prev <= din_q;
            irq      <= |((din_q ^ din_prev) & mask_q);    // One cycle per change

            if (lb.wr)
            begin
                case (lb.adr)
                    `PM_PIO_DOUT : dout_q <= wdat;
                    `PM_PIO_SET  : dout_q <= dout_q | wdat;
                    `PM_PIO_CLR  : dout_q <= dout_q & ~wdat;
                    `PM_PIO_MASK : mask_q <= wdat;
                    default      : ;
                endcase
            end
        end
    end

    // SET and CLR read back as zero
    always_comb
    begin
        rd_mux = '0;
        case (lb.adr)
            `PM_PIO_VER  : rd_mux = {16'h0, `PM_HW_VER_MAJOR, `PM_HW_VER_MINOR};
            `PM_PIO_DIN  : rd_mux[`PM_PIO_W-1:0] = din_q;
            `PM_PIO_DOUT : rd_mux[`PM_PIO_W-1:0] = dout_q;
            `PM_PIO_MASK : rd_mux[`PM_PIO_W-1:0] = mask_q;
            default      : rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (lb.rd)
            lb.dout <= rd_mux;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            lb.vld <= 1'b0;
        else
            lb.vld <= lb.rd;
    end

    assign pio_out = dout_q;

endmodule

/* hdl/pm_tmr.sv */
/*
    Timer with a beat prescaler, a free running beat counter and an alarm.
    irq pulses once when the counter reaches ALARM while CTL bit 0 is set.
*/
`timescale 1ns/100ps
`include "pm_defs.svh"

module pm_tmr
(
    input  logic    clk,
    input  logic    rst,
    pm_lb_if.dev    lb,
    output logic    irq
);

    localparam int PRE_W = $clog2(`PM_BEAT);

    logic [PRE_W-1:0]   pre_cnt;    // Prescaler
    logic               beat;
    pm_pkg::lb_dat_t    cnt_q;
    pm_pkg::lb_dat_t    cnt_nxt;
    pm_pkg::lb_dat_t    alarm_q;
    pm_pkg::lb_dat_t    ctl_q;      // Bit 0 alarm enable
    pm_pkg::lb_dat_t    rd_mux;

    assign beat    = (pre_cnt == PRE_W'(`PM_BEAT - 1));
    assign cnt_nxt = cnt_q + 1'b1;  // Wraps at the top

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pre_cnt <= '0;
            cnt_q   <= '0;
            alarm_q <= '0;
            ctl_q   <= '0;
            irq     <= 1'b0;
        end
        else
        begin
            pre_cnt <= beat ? '0 : pre_cnt + 1'b1;

            if (beat)
                cnt_q <= cnt_nxt;

            // Counter takes the alarm value at this beat
            irq <= beat && ctl_q[0] && (cnt_nxt == alarm_q);

            if (lb.wr)
            begin
                case (lb.adr)
                    `PM_TMR_ALARM : alarm_q <= lb.din;
                    `PM_TMR_CTL   : ctl_q   <= lb.din;
                    default       : ;   // CNT is read only
                endcase
            end
        end
    end

    always_comb
    begin
        case (lb.adr)
            `PM_TMR_CNT   : rd_mux = cnt_q;
            `PM_TMR_ALARM : rd_mux = alarm_q;
            `PM_TMR_CTL   : rd_mux = ctl_q;
            default       : rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (lb.rd)
            lb.dout <= rd_mux;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            lb.vld <= 1'b0;
        else
            lb.vld <= lb.rd;
    end

endmodule

/* hdl/pm_irq.sv */
/*
    Interrupt controller with sticky pending bits and a mask.
    The host interrupt line is high while any masked pending bit is set.
*/
`timescale 1ns/100ps
`include "pm_defs.svh"

module pm_irq
(
    input  logic                clk,
    input  logic                rst,
    pm_lb_if.dev                lb,
    input  pm_pkg::irq_vec_t    req,
    output logic                irq
);

    pm_pkg::irq_vec_t   pend_q;
    pm_pkg::irq_vec_t   mask_q;
    pm_pkg::irq_vec_t   clr;        // Write one to clear
    pm_pkg::lb_dat_t    rd_mux;

    assign clr = (lb.wr && (lb.adr == `PM_IRQ_PEND)) ? lb.din[`PM_IRQ_NUM-1:0] : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pend_q <= '0;
            mask_q <= '0;
            irq    <= 1'b0;
        end
        else
        begin
            pend_q <= (pend_q & ~clr) | req;    // New request beats the clear
            irq    <= |(pend_q & mask_q);

            if (lb.wr && (lb.adr == `PM_IRQ_MASK))
                mask_q <= lb.din[`PM_IRQ_NUM-1:0];
        end
    end

    always_comb
    begin
        rd_mux = '0;
        case (lb.adr)
            `PM_IRQ_PEND : rd_mux[`PM_IRQ_NUM-1:0] = pend_q;
            `PM_IRQ_MASK : rd_mux[`PM_IRQ_NUM-1:0] = mask_q;
            default      : rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (lb.rd)
            lb.dout <= rd_mux;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            lb.vld <= 1'b0;
        else
            lb.vld <= lb.rd;
    end

endmodule

/* hdl/pm_top.sv */
/*
    Policy maker peripheral block with a host bus decoder, PIO, timer and interrupt controller.
    The host reads and writes single words at 0xc100, 0xc200 and 0xc300.
*/
`timescale 1ns/100ps
`include "pm_defs.svh"

module pm_top
(
    input  logic                    clk,
    input  logic                    rst,

    // Host bus
    input  pm_pkg::host_adr_t       adr,
    input  logic                    wr,
    input  logic                    rd,
    input  pm_pkg::lb_dat_t         wr_dat,
    output pm_pkg::lb_dat_t         rd_dat,
    output logic                    rd_vld,

    // PIO pins
    input  logic [`PM_PIO_W-1:0]    pio_in,
    output logic [`PM_PIO_W-1:0]    pio_out,

    // Interrupts
    input  logic [1:0]              irq_in,
    output logic                    irq
);

    pm_lb_if pio_lb();
    pm_lb_if tmr_lb();
    pm_lb_if irq_lb();

    logic               pio_irq;
    logic               tmr_irq;
    pm_pkg::irq_vec_t   req;

    assign req = {irq_in, tmr_irq, pio_irq};    // External sources on top

    pm_lb_decoder u_dec
    (
        .clk        (clk),
        .rst        (rst),
        .adr        (adr),
        .wr         (wr),
        .rd         (rd),
        .wr_dat     (wr_dat),
        .rd_dat     (rd_dat),
        .rd_vld     (rd_vld),
        .pio_lb     (pio_lb),
        .tmr_lb     (tmr_lb),
        .irq_lb     (irq_lb)
    );

    pm_pio u_pio
    (
        .clk        (clk),
        .rst        (rst),
        .lb         (pio_lb),
        .pio_in     (pio_in),
        .pio_out    (pio_out),
        .irq        (pio_irq)
    );

    pm_tmr u_tmr
    (
        .clk        (clk),
        .rst        (rst),
        .lb         (tmr_lb),
        .irq        (tmr_irq)
    );

    pm_irq u_irq
    (
        .clk        (clk),
        .rst        (rst),
        .lb         (irq_lb),
        .req        (req),
        .irq        (irq)       // Host interrupt line
    );

endmodule

/* dv/pm_checker.sv */
/*
    Host bus timing assertions bound into the peripheral top level.
*/
`timescale 1ns/100ps

module pm_checker
(
    input logic clk,
    input logic rst,
    input logic rd,
    input logic rd_vld,
    input logic irq
);

    logic fail_follow = 1'b0;
    logic fail_cause = 1'b0;
    logic fail_reset = 1'b0;
    logic failed;

    assign failed = fail_follow | fail_cause | fail_reset;

    // Every read completes exactly one cycle later
    a_rd_follow : assert property (@(posedge clk) disable iff (rst) rd |=> rd_vld)
        else
        begin
            fail_follow = 1'b1;
            $error("rd_vld missing one cycle after rd");
        end

    a_vld_cause : assert property (@(posedge clk) disable iff (rst) rd_vld |-> $past(rd))
        else
        begin
            fail_cause = 1'b1;
            $error("rd_vld high without rd in the previous cycle");
        end

    // Quiet outputs right after reset
    a_reset_quiet : assert property (@(posedge clk) $past(rst) |-> !rd_vld && !irq)
        else
        begin
            fail_reset = 1'b1;
            $error("rd_vld or irq high just after reset");
        end

endmodule

bind pm_top pm_checker u_checker
(
    .clk    (clk),
    .rst    (rst),
    .rd     (rd),
    .rd_vld (rd_vld),
    .irq    (irq)
);

/* dv/pm_tb.sv */
/*
    Testbench for the peripheral block with host reads and writes checked against a register model.
    Compile it with sources.f; the bus checker is bound into the top level.
*/
`timescale 1ns/100ps
`include "pm_defs.svh"

module pm_tb;

    localparam int TMO = 1000;  // Cycles before any wait gives up

    logic                   clk = 1'b0;
    logic                   rst;
    pm_pkg::host_adr_t      adr;
    logic                   wr;
    logic                   rd;
    pm_pkg::lb_dat_t        wr_dat;
    pm_pkg::lb_dat_t        rd_dat;
    logic                   rd_vld;
    logic [`PM_PIO_W-1:0]   pio_in;
    logic [`PM_PIO_W-1:0]   pio_out;
    logic [1:0]             irq_in;
    logic                   irq;

    // Register model
    logic [`PM_PIO_W-1:0]   m_dout;
    logic [`PM_PIO_W-1:0]   m_pmask;
    logic [`PM_PIO_W-1:0]   m_din;
    pm_pkg::lb_dat_t        m_alarm;
    pm_pkg::lb_dat_t        m_ctl;
    pm_pkg::irq_vec_t       m_pend;
    pm_pkg::irq_vec_t       m_imask;

    logic [15:0]            lfsr = 16'd54;
    pm_pkg::lb_dat_t        exp_q[$];   // Expected data per outstanding read
    pm_pkg::host_adr_t      adr_q[$];
    bit                     chk_q[$];
    pm_pkg::lb_dat_t        c_exp;
    pm_pkg::host_adr_t      c_adr;
    bit                     c_chk;
    pm_pkg::lb_dat_t        rd_last;
    int                     cyc = 0;
    int                     rd_done = 0;
    int                     vld_cyc = 0;
    int                     vld_gap = 0;
    int                     issue_cyc = 0;

    always #4 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    pm_top u_pm_top
    (
        .clk        (clk),
        .rst        (rst),
        .adr        (adr),
        .wr         (wr),
        .rd         (rd),
        .wr_dat     (wr_dat),
        .rd_dat     (rd_dat),
        .rd_vld     (rd_vld),
        .pio_in     (pio_in),
        .pio_out    (pio_out),
        .irq_in     (irq_in),
        .irq        (irq)
    );

    function automatic pm_pkg::host_adr_t reg_adr(input logic [3:0] dev, input logic [2:0] idx);
        return {`PM_PERIPH_SPACE, 2'b00, dev, 3'b000, idx, 2'b00};
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic pm_pkg::lb_dat_t lfsr_bits(input int n);
        pm_pkg::lb_dat_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Expected read data; CNT is not modelled and reads as zero here
    function automatic pm_pkg::lb_dat_t ref_reg(input pm_pkg::host_adr_t a);
        if (a[15:14] != `PM_PERIPH_SPACE)
            return '0;
        case ({a[11:8], a[4:2]})
            {`PM_DEV_PIO, `PM_PIO_VER}   : return 32'h0000_0100;   // Version 1.0
            {`PM_DEV_PIO, `PM_PIO_DIN}   : return 32'(m_din);
            {`PM_DEV_PIO, `PM_PIO_DOUT}  : return 32'(m_dout);
            {`PM_DEV_PIO, `PM_PIO_MASK}  : return 32'(m_pmask);
            {`PM_DEV_TMR, `PM_TMR_ALARM} : return m_alarm;
            {`PM_DEV_TMR, `PM_TMR_CTL}   : return m_ctl;
            {`PM_DEV_IRQ, `PM_IRQ_PEND}  : return 32'(m_pend);
            {`PM_DEV_IRQ, `PM_IRQ_MASK}  : return 32'(m_imask);
            default                      : return '0;
        endcase
    endfunction

    function automatic void ref_write(input pm_pkg::host_adr_t a, input pm_pkg::lb_dat_t d);
        if (a[15:14] != `PM_PERIPH_SPACE)
            return;
        case ({a[11:8], a[4:2]})
            {`PM_DEV_PIO, `PM_PIO_DOUT}  : m_dout = d[`PM_PIO_W-1:0];
            {`PM_DEV_PIO, `PM_PIO_SET}   : m_dout = m_dout | d[`PM_PIO_W-1:0];
            {`PM_DEV_PIO, `PM_PIO_CLR}   : m_dout = m_dout & ~d[`PM_PIO_W-1:0];
            {`PM_DEV_PIO, `PM_PIO_MASK}  : m_pmask = d[`PM_PIO_W-1:0];
            {`PM_DEV_TMR, `PM_TMR_ALARM} : m_alarm = d;
            {`PM_DEV_TMR, `PM_TMR_CTL}   : m_ctl = d;
            {`PM_DEV_IRQ, `PM_IRQ_PEND}  : m_pend = m_pend & ~d[`PM_IRQ_NUM-1:0];
            {`PM_DEV_IRQ, `PM_IRQ_MASK}  : m_imask = d[`PM_IRQ_NUM-1:0];
            default                      : ;
        endcase
    endfunction

    task automatic stop_fail();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_val(input string name, input pm_pkg::lb_dat_t got,
                             input pm_pkg::lb_dat_t exp);
        if (got !== exp)
        begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_fail();
        end
    endtask

    task automatic queue_exp(input pm_pkg::host_adr_t a, input bit chk);
        exp_q.push_back(ref_reg(a));
        adr_q.push_back(a);
        chk_q.push_back(chk);
    endtask

    task automatic wait_reads(input int target);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (n > TMO)
            begin
                $display("timeout: read data never came back on rd_vld");
                stop_fail();
            end
        end
        while (rd_done < target);
    endtask

    task automatic bus_write(input pm_pkg::host_adr_t a, input pm_pkg::lb_dat_t d);
        ref_write(a, d);
        @(negedge clk);
        adr    = a;
        wr_dat = d;
        wr     = 1'b1;
        @(negedge clk);
        wr     = 1'b0;
    endtask

    task automatic bus_read(input pm_pkg::host_adr_t a, input bit chk,
                            output pm_pkg::lb_dat_t d);
        int target;
        target = rd_done + 1;
        queue_exp(a, chk);
        @(negedge clk);
        adr       = a;
        rd        = 1'b1;
        issue_cyc = cyc;
        @(negedge clk);
        rd        = 1'b0;
        wait_reads(target);
        d = rd_last;
    endtask

    // Reads on consecutive cycles return data on consecutive cycles
    task automatic read_pair(input pm_pkg::host_adr_t a0, input pm_pkg::host_adr_t a1);
        int target;
        target = rd_done + 2;
        queue_exp(a0, 1'b1);
        queue_exp(a1, 1'b1);
        @(negedge clk);
        adr = a0;
        rd  = 1'b1;
        @(negedge clk);
        adr = a1;
        @(negedge clk);
        rd  = 1'b0;
        wait_reads(target);
        check_val("rd_vld gap", 32'(vld_gap), 32'd1);
    endtask

    task automatic wait_irq(input logic lvl, input string what);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > TMO)
            begin
                $display("timeout waiting for %s", what);
                stop_fail();
            end
        end
        while (irq !== lvl);
    endtask

    // Compare every returned read with the model
    always @(negedge clk)
    begin
        if (!rst && rd_vld)
        begin
            if (exp_q.size() == 0)
            begin
                $display("rd_vld came back with no read outstanding");
                stop_fail();
            end
            else
            begin
                c_exp   = exp_q.pop_front();
                c_adr   = adr_q.pop_front();
                c_chk   = chk_q.pop_front();
                rd_last = rd_dat;
                vld_gap = cyc - vld_cyc;
                vld_cyc = cyc;
                rd_done++;
                if (c_chk)
                    check_val($sformatf("rd_dat at 0x%h", c_adr), rd_dat, c_exp);
            end
        end
    end

    always @(negedge clk)
    begin
        if (u_pm_top.u_checker.failed)
        begin
            $display("a bus timing assertion failed");
            stop_fail();
        end
    end

    initial
    begin
        pm_pkg::lb_dat_t d;
        pm_pkg::lb_dat_t c0;
        pm_pkg::lb_dat_t c1;
        int t0;
        int lo;
        rst     = 1'b1;
        adr     = '0;
        wr      = 1'b0;
        rd      = 1'b0;
        wr_dat  = '0;
        pio_in  = '0;
        irq_in  = 2'b00;
        m_dout  = '0;
        m_pmask = '0;
        m_din   = '0;
        m_alarm = '0;
        m_ctl   = '0;
        m_pend  = '0;
        m_imask = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_val("pio_out", 32'(pio_out), '0);

        // Reset values, then unmapped addresses
        bus_read(reg_adr(`PM_DEV_PIO, `PM_PIO_VER), 1'b1, d);
        check_val("version", d, 32'h0000_0100);
        bus_read(reg_adr(`PM_DEV_PIO, `PM_PIO_DOUT), 1'b1, d);
        bus_read(reg_adr(`PM_DEV_TMR, `PM_TMR_ALARM), 1'b1, d);
        bus_read(reg_adr(`PM_DEV_TMR, `PM_TMR_CTL), 1'b1, d);
        bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_PEND), 1'b1, d);
        bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_MASK), 1'b1, d);
        bus_read(reg_adr(4'd0, 3'd1), 1'b1, d);
        bus_read(reg_adr(4'd9, 3'd2), 1'b1, d);
        bus_read(16'h0104, 1'b1, d);    // Outside peripheral space

        // DOUT with set and clear
        for (int i = 0; i < 8; i++)
        begin
            bus_write(reg_adr(`PM_DEV_PIO, `PM_PIO_DOUT), lfsr_bits(32));
            bus_write(reg_adr(`PM_DEV_PIO, `PM_PIO_SET), lfsr_bits(32));
            bus_write(reg_adr(`PM_DEV_PIO, `PM_PIO_CLR), lfsr_bits(32));
            check_val("pio_out", 32'(pio_out), 32'(m_dout));
            bus_read(reg_adr(`PM_DEV_PIO, `PM_PIO_DOUT), 1'b1, d);
        end
        read_pair(reg_adr(`PM_DEV_PIO, `PM_PIO_DOUT), reg_adr(`PM_DEV_PIO, `PM_PIO_VER));
        read_pair(reg_adr(4'd7, 3'd0), reg_adr(`PM_DEV_IRQ, `PM_IRQ_MASK));

        // Input sampling and the change interrupt
        for (int i = 0; i < 6; i++)
        begin
            @(negedge clk);
            d      = lfsr_bits(`PM_PIO_W);
            pio_in = d[`PM_PIO_W-1:0];
            m_din  = pio_in;
            bus_read(reg_adr(`PM_DEV_PIO, `PM_PIO_DIN), 1'b1, d);
        end
        bus_write(reg_adr(`PM_DEV_PIO, `PM_PIO_MASK), 32'hff);
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_MASK), 32'h1);
        @(negedge clk);
        pio_in = ~pio_in;
        m_din  = pio_in;
        wait_irq(1'b1, "irq after a PIO input change");
        m_pend[0] = 1'b1;
        bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_PEND), 1'b1, d);
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_PEND), 32'h1);
        wait_irq(1'b0, "irq to fall after clearing PEND bit 0");
        bus_write(reg_adr(`PM_DEV_PIO, `PM_PIO_MASK), 32'h0);

        // Timer count rate, then the alarm
        bus_read(reg_adr(`PM_DEV_TMR, `PM_TMR_CNT), 1'b0, c0);
        t0 = issue_cyc;
        repeat (300) @(posedge clk);
        bus_read(reg_adr(`PM_DEV_TMR, `PM_TMR_CNT), 1'b0, c1);
        lo = (issue_cyc - t0) / `PM_BEAT;
        if (int'(c1 - c0) < lo || int'(c1 - c0) > lo + 1)
        begin
            $display("error timer CNT: moved 0x%h over %0d cycles", c1 - c0, issue_cyc - t0);
            stop_fail();
        end
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_MASK), 32'h2);
        bus_write(reg_adr(`PM_DEV_TMR, `PM_TMR_ALARM), c1 + 32'd3);
        bus_write(reg_adr(`PM_DEV_TMR, `PM_TMR_CTL), 32'h1);
        wait_irq(1'b1, "the timer alarm interrupt");
        m_pend[1] = 1'b1;
        bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_PEND), 1'b1, d);
        bus_read(reg_adr(`PM_DEV_TMR, `PM_TMR_ALARM), 1'b1, d);
        bus_write(reg_adr(`PM_DEV_TMR, `PM_TMR_CTL), 32'h0);
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_PEND), 32'h2);
        wait_irq(1'b0, "irq to fall after clearing PEND bit 1");
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_MASK), 32'h0);

        // External requests stay quiet until unmasked
        @(negedge clk);
        irq_in = 2'b11;
        @(negedge clk);
        irq_in = 2'b00;
        m_pend[3:2] = 2'b11;
        bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_PEND), 1'b1, d);
        @(negedge clk);
        check_val("irq", 32'(irq), '0);
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_MASK), 32'hc);
        wait_irq(1'b1, "irq once the external bits are unmasked");
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_PEND), 32'hc);
        wait_irq(1'b0, "irq to fall after clearing PEND bits 3:2");

        @(negedge clk);
        if (!u_pm_top.u_checker.failed)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
            stop_fail();
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/pm_pkg.sv
hdl/pm_lb_if.sv
hdl/pm_lb_decoder.sv
hdl/pm_pio.sv
hdl/pm_tmr.sv
hdl/pm_irq.sv
hdl/pm_top.sv
dv/pm_checker.sv
dv/pm_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and decide the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module pm_tb -f sources.f -o pm_sim
./obj_dir/pm_sim 2>&1 | tee sim.log

if grep -qx "PASS: all tests" sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
